/* Makefile */
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/rob_tb.sv */
// batches must open with a row that waits for writeback; rows after a flush in a batch must die
`default_nettype none
`timescale 1ns/10ps

`include "rob_defs.svh"

module rob_tb
  import op_pkg::*;
();

  localparam int DEPTH = `ROB_DEPTH;
  localparam int NFIX  = 20;
  localparam int NROWS = NFIX + DEPTH + 2;
  localparam logic [`PC_W-1:0] TVEC = 30'h200;

  // retire class bit order is branch, csr, serialize, store, br_invert
  localparam logic [4:0] OP_ALU    = 5'b00000;
  localparam logic [4:0] OP_BR     = 5'b10000;
  localparam logic [4:0] OP_BRI    = 5'b10001;
  localparam logic [4:0] OP_CSR    = 5'b01000;
  localparam logic [4:0] OP_CSRSER = 5'b01100;
  localparam logic [4:0] OP_ST     = 5'b00010;
  localparam logic [5:0] NO_DST    = 6'h20;

  localparam ecause_t C_NONE = ECAUSE_FETCH_MISALIGNED;
  localparam ecause_t C_ILL  = ECAUSE_ILLEGAL;
  localparam ecause_t C_LDF  = ECAUSE_LOAD_FAULT;

  typedef struct packed {
    retop_t           op;
    dest_t            dst;
    logic             fwd;
    logic             derr;
    logic             wberr;
    ecause_t          cause;
    logic [31:0]      res;
    logic [`PC_W-1:0] tgt;
    logic             bpt;
    logic             brk;
    logic             xfl;
    logic [`PC_W-1:0] xpc;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  decode_valid;
  logic                  decode_error;
  logic [1:0]            decode_ecause;
  retop_t                decode_retop;
  logic [`PC_W-1:0]      decode_pc;
  dest_t                 decode_dest;
  logic [`BPTAG_W-1:0]   decode_bptag;
  logic                  decode_bptaken;
  logic                  decode_forward;
  logic [`PC_W-1:0]      decode_target;
  logic                  full;
  logic [`ROB_IDX_W-1:0] robid;
  logic                  wb_valid;
  logic                  wb_error;
  ecause_t               wb_ecause;
  logic [`ROB_IDX_W-1:0] wb_robid;
  logic [`XLEN-1:0]      wb_result;
  logic [`PC_W-1:0]      csr_tvec;
  logic                  flush;
  logic [`PC_W-1:0]      flush_pc;
  logic                  ret_valid;
  logic                  commit;
  logic [`REG_IDX_W-1:0] commit_idx;
  logic [`XLEN-1:0]      commit_data;
  logic                  ret_store;
  logic                  ret_branch;
  logic [`BPTAG_W-1:0]   ret_bptag;
  logic                  ret_bptaken;
  logic                  ret_csr;
  logic                  csr_valid;
  logic [`PC_W-1:0]      csr_epc;
  ecause_t               csr_ecause;
  logic [`REG_IDX_W-1:0] rd_idx;
  logic [`XLEN-1:0]      rd_data;

  row_t                  tbl [NROWS];
  logic [`ROB_IDX_W-1:0] slot [NROWS];
  logic [31:0]           model_rf [32];
  int                    exp_q [$];
  int                    pend [$];
  int                    n_checks;
  int                    n_val_err;
  int                    n_other_err;
  logic                  flushed;
  logic                  batch_flush;

  rob_top dut (
    .clk(clk), .rst_n(rst_n),
    .decode_valid(decode_valid), .decode_error(decode_error),
    .decode_ecause(decode_ecause), .decode_retop(decode_retop),
    .decode_pc(decode_pc), .decode_dest(decode_dest),
    .decode_bptag(decode_bptag), .decode_bptaken(decode_bptaken),
    .decode_forward(decode_forward), .decode_target(decode_target),
    .full(full), .robid(robid),
    .wb_valid(wb_valid), .wb_error(wb_error), .wb_ecause(wb_ecause),
    .wb_robid(wb_robid), .wb_result(wb_result), .csr_tvec(csr_tvec),
    .flush(flush), .flush_pc(flush_pc), .ret_valid(ret_valid),
    .commit(commit), .commit_idx(commit_idx), .commit_data(commit_data),
    .ret_store(ret_store), .ret_branch(ret_branch), .ret_bptag(ret_bptag),
    .ret_bptaken(ret_bptaken), .ret_csr(ret_csr),
    .csr_valid(csr_valid), .csr_epc(csr_epc), .csr_ecause(csr_ecause),
    .rd_idx(rd_idx), .rd_data(rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [`PC_W-1:0] row_pc(input int r);
    return 30'h1000 + r[`PC_W-1:0];
  endfunction

  function automatic logic [`BPTAG_W-1:0] row_tag(input int r);
    return 16'hb000 + r[15:0];
  endfunction

  function automatic void build_table();
    int k;
    int dreg;
    // op, dst, fwd, derr, wberr, cause, result, target, bptaken, brk, exp flush, exp pc
    tbl[0]  = '{OP_ALU, 6'h05, 0, 0, 0, C_NONE, 32'h1111_0005, 30'h000, 0, 0, 0, 30'h000};
    tbl[1]  = '{OP_ST, 6'h06, 0, 0, 0, C_NONE, 32'h0000_0000, 30'h000, 0, 0, 0, 30'h000};
    tbl[2]  = '{OP_BR, NO_DST, 0, 0, 0, C_NONE, 32'h0000_0001, 30'h155, 1, 0, 0, 30'h000};
    tbl[3]  = '{OP_ALU, 6'h00, 0, 0, 0, C_NONE, 32'hdead_beef, 30'h000, 0, 0, 0, 30'h000};
    tbl[4]  = '{OP_CSR, 6'h07, 0, 0, 0, C_NONE, 32'h0000_0c5a, 30'h000, 0, 0, 0, 30'h000};
    tbl[5]  = '{OP_BRI, NO_DST, 0, 0, 0, C_NONE, 32'h0000_0001, 30'h166, 0, 0, 0, 30'h000};
    tbl[6]  = '{OP_ALU, 6'h05, 0, 0, 0, C_NONE, 32'h5555_0005, 30'h000, 0, 0, 0, 30'h000};
    tbl[7]  = '{OP_ALU, 6'h01, 1, 0, 0, C_NONE, 32'h0000_0880, 30'h123, 0, 1, 0, 30'h000};
    // mispredicted branch, then one younger entry that must die
    tbl[8]  = '{OP_ALU, 6'h08, 0, 0, 0, C_NONE, 32'h0808_0808, 30'h000, 0, 0, 0, 30'h000};
    tbl[9]  = '{OP_BR, NO_DST, 0, 0, 0, C_NONE, 32'h0000_0000, 30'h777, 1, 0, 1, 30'h777};
    tbl[10] = '{OP_ALU, 6'h09, 0, 0, 0, C_NONE, 32'h0000_9999, 30'h000, 0, 1, 0, 30'h000};
    // forwarded branch redirects to its result
    tbl[11] = '{OP_BR, 6'h0a, 1, 0, 0, C_NONE, 32'h0000_0a01, 30'h124, 0, 0, 1, 30'h280};
    tbl[12] = '{OP_ALU, 6'h0b, 0, 0, 0, C_NONE, 32'h1111_1111, 30'h000, 0, 1, 0, 30'h000};
    tbl[13] = '{OP_ALU, 6'h0c, 0, 0, 0, C_NONE, 32'h0c0c_0c0c, 30'h000, 0, 0, 0, 30'h000};
    tbl[14] = '{OP_ALU, 6'h0d, 0, 1, 0, C_ILL, 32'h0000_0000, 30'h000, 0, 0, 1, TVEC};
    tbl[15] = '{OP_ALU, 6'h0e, 0, 0, 0, C_NONE, 32'h0000_0e0e, 30'h000, 0, 1, 0, 30'h000};
    tbl[16] = '{OP_ALU, 6'h0f, 0, 0, 1, C_LDF, 32'h0000_0000, 30'h000, 0, 0, 1, TVEC};
    tbl[17] = '{OP_ST, NO_DST, 0, 0, 0, C_NONE, 32'h0000_0000, 30'h000, 0, 1, 0, 30'h000};
    tbl[18] = '{OP_CSRSER, 6'h10, 0, 0, 0, C_NONE, 32'h0000_0016, 30'h333, 0, 0, 1, 30'h333};
    tbl[19] = '{OP_ALU, 6'h11, 0, 0, 0, C_NONE, 32'h0000_1717, 30'h000, 0, 1, 0, 30'h000};
    // one batch longer than the queue so that full rises
    for (k = 0; k < DEPTH + 2; k++) begin
      dreg = 18 + k % 10;
      tbl[NFIX + k] = '{OP_ALU, {1'b0, dreg[4:0]}, 0, 0, 0, C_NONE, {16'hf00d, k[15:0]},
                        30'h000, 0, k == DEPTH + 1, 0, 30'h000};
    end
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_val_err++;
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other errors %0d", n_checks, n_val_err, n_other_err);
  endtask

  task automatic check_retire();
    int r;
    row_t e;
    logic err;
    logic taken;
    logic wr;
    logic [31:0] cval;
    if (exp_q.size() == 0) begin
      n_other_err++;
      $display("retirement of pc %h seen when no entry should retire", csr_epc);
      return;
    end
    r = exp_q.pop_front();
    e = tbl[r];
    err = e.derr || e.wberr;
    taken = e.res[0] ^ e.op.br_invert;
    wr = !err && !e.dst.none && !e.op.store;
    cval = e.fwd ? {e.tgt, 2'b00} : e.res;
    expect_eq("csr_epc", csr_epc, row_pc(r));
    expect_eq("ret_valid", ret_valid, !err);
    expect_eq("csr_valid", csr_valid, err);
    expect_eq("flush", flush, e.xfl);
    if (e.xfl) begin
      expect_eq("flush_pc", flush_pc, e.xpc);
    end
    if (err) begin
      expect_eq("csr_ecause", csr_ecause, e.cause);
    end
    expect_eq("ret_store", ret_store, !err && e.op.store);
    expect_eq("ret_csr", ret_csr, !err && e.op.csr);
    expect_eq("ret_branch", ret_branch, !err && e.op.branch);
    if (!err && e.op.branch) begin
      expect_eq("ret_bptag", ret_bptag, row_tag(r));
      expect_eq("ret_bptaken", ret_bptaken, taken);
    end
    expect_eq("commit", commit, wr);
    if (wr) begin
      expect_eq("commit_idx", commit_idx, e.dst.idx);
      expect_eq("commit_data", commit_data, cval);
      if (e.dst.idx != 0) begin
        model_rf[e.dst.idx] = cval;
      end
    end
  endtask

  // retire side checker, sampled before the edge updates anything
  always @(posedge clk) begin
    if (rst_n) begin
      if (flush) begin
        flushed = 1'b1;
      end
      if (ret_valid || csr_valid) begin
        check_retire();
      end else begin
        expect_eq("idle strobes", {flush, commit, ret_store, ret_csr, ret_branch}, 5'b0);
      end
    end
  end

  task automatic drive_row(input int r);
    decode_valid   = 1'b1;
    decode_error   = tbl[r].derr;
    decode_ecause  = tbl[r].cause[1:0];
    decode_retop   = tbl[r].op;
    decode_pc      = row_pc(r);
    decode_dest    = tbl[r].dst;
    decode_bptag   = row_tag(r);
    decode_bptaken = tbl[r].bpt;
    decode_forward = tbl[r].fwd;
    decode_target  = tbl[r].tgt;
  endtask

  // shuffled writebacks; stops once the queue has flushed
  task automatic issue_writebacks();
    int j;
    int k;
    int t;
    for (j = pend.size() - 1; j > 0; j--) begin
      k = int'($urandom_range(j, 0));
      t = pend[j];
      pend[j] = pend[k];
      pend[k] = t;
    end
    foreach (pend[i]) begin
      @(negedge clk);
      wb_valid  = !flushed;
      wb_robid  = slot[pend[i]];
      wb_error  = tbl[pend[i]].wberr;
      wb_ecause = tbl[pend[i]].cause;
      wb_result = tbl[pend[i]].res;
    end
    @(negedge clk);
    wb_valid = 1'b0;
    pend.delete();
  endtask

  task automatic run_batch(input int first, input int last);
    int r;
    int n_acc;
    int stall;
    logic accepted;
    logic saw_full;
    logic [`ROB_IDX_W-1:0] held_id;
    flushed = 1'b0;
    batch_flush = 1'b0;
    n_acc = 0;
    saw_full = 1'b0;
    held_id = '0;
    for (r = first; r <= last && !batch_flush; r++) begin
      exp_q.push_back(r);
      batch_flush = tbl[r].xfl;
    end
    for (r = first; r <= last; r++) begin
      @(negedge clk);
      drive_row(r);
      accepted = 1'b0;
      stall = 0;
      while (!accepted) begin
        @(posedge clk);
        if (!full) begin
          accepted = 1'b1;
          slot[r] = robid;
          n_acc++;
          if (!tbl[r].derr && !tbl[r].op.store) begin
            pend.push_back(r);
          end
        end else begin
          saw_full = 1'b1;
          if (stall == 0) begin
            held_id = robid;
            expect_eq("accepted before full", n_acc, DEPTH);
          end
          expect_eq("robid", robid, held_id);
          stall++;
          if (stall == 4) begin
            @(negedge clk);
            decode_valid = 1'b0;
            issue_writebacks();
            drive_row(r);
          end
        end
      end
    end
    if ((last - first + 1 > DEPTH) && !saw_full) begin
      n_other_err++;
      $display("full never rose although the batch is longer than the queue");
    end
    @(negedge clk);
    decode_valid = 1'b0;
    issue_writebacks();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // room for any stray retirement to show up
    repeat (4) @(posedge clk);
    if (batch_flush) begin
      expect_eq("robid", robid, 0);
    end
    expect_eq("full", full, 0);
  endtask

  initial begin
    repeat (NROWS * 40 + 200) @(posedge clk);
    n_other_err++;
    $display("timeout: the run did not finish in the expected number of cycles");
    print_counts();
    $display("sim failed");
    $finish;
  end

  initial begin
    int r;
    int first;
    void'($urandom(32'hbd88));
    rst_n = 1'b0;
    decode_valid = 1'b0;
    decode_error = 1'b0;
    decode_ecause = 2'b00;
    decode_retop = '0;
    decode_pc = '0;
    decode_dest = '0;
    decode_bptag = '0;
    decode_bptaken = 1'b0;
    decode_forward = 1'b0;
    decode_target = '0;
    wb_valid = 1'b0;
    wb_error = 1'b0;
    wb_ecause = C_NONE;
    wb_robid = '0;
    wb_result = '0;
    csr_tvec = TVEC;
    rd_idx = '0;
    n_checks = 0;
    n_val_err = 0;
    n_other_err = 0;
    flushed = 1'b0;
    for (r = 0; r < 32; r++) begin
      model_rf[r] = '0;
    end
    build_table();

    repeat (4) @(posedge clk);
    expect_eq("reset outputs", {ret_valid, flush, commit, csr_valid, ret_store, ret_branch,
                                ret_csr, full}, 8'h00);
    expect_eq("robid", robid, 0);
    @(negedge clk);
    rst_n = 1'b1;

    first = 0;
    for (r = 0; r < NROWS; r++) begin
      if (tbl[r].brk) begin
        run_batch(first, r);
        first = r + 1;
      end
    end

    // architectural state after the whole sequence
    for (r = 0; r < 32; r++) begin
      @(negedge clk);
      rd_idx = r[4:0];
      @(posedge clk);
      expect_eq($sformatf("rd_data x%0d", r), rd_data, model_rf[r]);
    end

    print_counts();
    if (n_val_err + n_other_err == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/arch_regfile.sv */
// 32 x XLEN registers, one write and one combinational read; x0 is hardwired to zero
`default_nettype none
`timescale 1ns/10ps

`include "rob_defs.svh"

module arch_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  commit,
  input  logic [`REG_IDX_W-1:0] commit_idx,
  input  logic [`XLEN-1:0]      commit_data,
  input  logic [`REG_IDX_W-1:0] rd_idx,
  output logic [`XLEN-1:0]      rd_data
);

  localparam int unsigned NREGS = 1 << `REG_IDX_W;

  logic [`XLEN-1:0] regs [NREGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (commit && (commit_idx != '0)) begin
      regs[commit_idx] <= commit_data;
    end
  end

  // x0 never holds a value
  assign rd_data = (rd_idx == '0) ? '0 : regs[rd_idx];

endmodule

`default_nettype wire

/* design/op_pkg.sv */
// decoded instruction view only; cause codes outside the named set pass through unnamed
`default_nettype none

`include "rob_defs.svh"

package op_pkg;

  // how an instruction behaves when it retires
  typedef struct packed {
    logic branch;
    logic csr;
    logic serialize;
    logic store;
    logic br_invert;
  } retop_t;

  // destination register, none set means no writeback
  typedef struct packed {
    logic                  none;
    logic [`REG_IDX_W-1:0] idx;
  } dest_t;

  typedef enum logic [4:0] {
    ECAUSE_FETCH_MISALIGNED = 5'd0,
    ECAUSE_FETCH_FAULT      = 5'd1,
    ECAUSE_ILLEGAL          = 5'd2,
    ECAUSE_LOAD_FAULT       = 5'd5,
    ECAUSE_STORE_FAULT      = 5'd7
  } ecause_t;

endpackage

`default_nettype wire

/* design/ret_pkg.sv */
// one queue entry layout; forwarded jumps keep the link in target and the destination in result
`default_nettype none

`include "rob_defs.svh"

package ret_pkg;

  import op_pkg::*;

  typedef struct packed {
    logic                error;
    ecause_t             ecause;
    retop_t              retop;
    logic [`PC_W-1:0]    pc;
    dest_t               dest;
    logic [`XLEN-1:0]    result;
    logic [`PC_W-1:0]    target;
    logic [`BPTAG_W-1:0] bptag;
    logic                bptaken;
    logic                forwarded;
  } rob_entry_t;

endpackage

`default_nettype wire

/* design/retire_unit.sv */
// purely combinational; outputs are meaningful only while ret_valid is high
`default_nettype none
`timescale 1ns/10ps

`include "rob_defs.svh"

module retire_unit
  import op_pkg::*, ret_pkg::*;
(
  input  logic                  ret_valid,
  input  rob_entry_t            ret_entry,
  input  logic [`PC_W-1:0]      csr_tvec,
  output logic                  flush,
  output logic [`PC_W-1:0]      flush_pc,
  output logic                  ret_ok,
  output logic                  commit,
  output logic [`REG_IDX_W-1:0] commit_idx,
  output logic [`XLEN-1:0]      commit_data,
  output logic                  ret_store,
  output logic                  ret_branch,
  output logic [`BPTAG_W-1:0]   ret_bptag,
  output logic                  ret_bptaken,
  output logic                  ret_csr,
  output logic                  csr_valid,
  output logic [`PC_W-1:0]      csr_epc,
  output ecause_t               csr_ecause
);

  logic br_taken;
  logic mispredict;
  logic exc;
  logic redirect;

  // br_invert flips the sense of result bit 0
  assign br_taken   = ret_entry.result[0] ^ ret_entry.retop.br_invert;
  assign mispredict = ret_entry.retop.branch && (br_taken != ret_entry.bptaken);

  assign ret_ok   = ret_valid && !ret_entry.error;
  assign exc      = ret_valid && ret_entry.error;
  assign redirect = ret_ok && (ret_entry.retop.serialize || mispredict);
  assign flush    = exc || redirect;

  // traps go to the vector, everything else to the computed destination
  assign flush_pc = ret_entry.error     ? csr_tvec :
                    ret_entry.forwarded ? ret_entry.result[`PC_W+1:2] :
                                          ret_entry.target;

  // jumps write back their link address
  assign commit      = ret_ok && !ret_entry.dest.none && !ret_entry.retop.store;
  assign commit_idx  = ret_entry.dest.idx;
  assign commit_data = ret_entry.forwarded ? {ret_entry.target, 2'b00} : ret_entry.result;

  assign ret_store   = ret_ok && ret_entry.retop.store;
  assign ret_csr     = ret_ok && ret_entry.retop.csr;

  // predictor update gets the resolved direction
  assign ret_branch  = ret_ok && ret_entry.retop.branch;
  assign ret_bptag   = ret_entry.bptag;
  assign ret_bptaken = br_taken;

  assign csr_valid  = exc;
  assign csr_epc    = ret_entry.pc;
  assign csr_ecause = ret_entry.ecause;

endmodule

`default_nettype wire

/* design/rob_defs.svh */
// queue depth is a power of two set by ROB_IDX_W (2 to 7); PCs are word aligned, bits 31:2 only
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// queue index width, depth follows from it
`define ROB_IDX_W 4
`define ROB_DEPTH (1 << `ROB_IDX_W)

// data path width of the core
`define XLEN 32

// word-aligned pc, bits 31 down to 2
`define PC_W 30

// branch predictor tag carried through to retirement
`define BPTAG_W 16

// architectural register index
`define REG_IDX_W 5

`endif

/* design/rob_queue.sv */
// one decode, one writeback per cycle; writebacks target occupied slots, dropped after a flush
`default_nettype none
`timescale 1ns/10ps

`include "rob_defs.svh"

module rob_queue
  import op_pkg::*, ret_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  decode_valid,
  input  logic                  decode_error,
  input  logic [1:0]            decode_ecause,
  input  retop_t                decode_retop,
  input  logic [`PC_W-1:0]      decode_pc,
  input  dest_t                 decode_dest,
  input  logic [`BPTAG_W-1:0]   decode_bptag,
  input  logic                  decode_bptaken,
  input  logic                  decode_forward,
  input  logic [`PC_W-1:0]      decode_target,
  output logic                  full,
  output logic [`ROB_IDX_W-1:0] robid,
  input  logic                  wb_valid,
  input  logic                  wb_error,
  input  ecause_t               wb_ecause,
  input  logic [`ROB_IDX_W-1:0] wb_robid,
  input  logic [`XLEN-1:0]      wb_result,
  input  logic                  flush,
  output logic                  ret_valid,
  output rob_entry_t            ret_entry
);

  localparam int unsigned DEPTH = `ROB_DEPTH;

  // pointers carry a wrap bit above the index
  logic [`ROB_IDX_W:0]   head_ptr;
  logic [`ROB_IDX_W:0]   tail_ptr;
  logic [`ROB_IDX_W:0]   head_next;
  logic [`ROB_IDX_W:0]   rd_ptr;
  logic [`ROB_IDX_W:0]   occupancy;
  logic [`ROB_IDX_W-1:0] wb_offset;
  logic                  wb_in_range;
  logic                  rd_empty;
  logic                  decode_beat;
  logic                  wb_beat;
  logic                  wb_block;
  logic [DEPTH-1:0]      executed;
  rob_entry_t            mem [DEPTH];

  // look ahead one slot while the current head is retiring
  assign head_next = head_ptr + 1'b1;
  assign rd_ptr    = ret_valid ? head_next : head_ptr;
  assign rd_empty  = (rd_ptr == tail_ptr);

  assign full  = (head_ptr[`ROB_IDX_W-1:0] == tail_ptr[`ROB_IDX_W-1:0]) &&
                 (head_ptr[`ROB_IDX_W] != tail_ptr[`ROB_IDX_W]);
  assign robid = tail_ptr[`ROB_IDX_W-1:0];

  assign decode_beat = decode_valid && !full;
  assign wb_beat     = wb_valid && !wb_block;

  // occupied slots run from head up to tail minus one
  assign occupancy   = tail_ptr - head_ptr;
  assign wb_offset   = wb_robid - head_ptr[`ROB_IDX_W-1:0];
  assign wb_in_range = ({1'b0, wb_offset} < occupancy);

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head_ptr <= '0;
    end else if (ret_valid) begin
      head_ptr <= head_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      tail_ptr <= '0;
    end else if (decode_beat) begin
      tail_ptr <= tail_ptr + 1'b1;
    end
  end

  // writebacks still in the pipe from before a flush arrive one cycle late
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_block <= 1'b0;
    end else begin
      wb_block <= flush;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      executed <= '0;
    end else begin
      if (decode_beat) begin
        executed[robid] <= decode_error || decode_retop.store;
      end
      if (wb_beat) begin
        executed[wb_robid] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (decode_beat) begin
      mem[robid] <= '{
        error:     decode_error,
        ecause:    ecause_t'({3'b000, decode_ecause}),
        retop:     decode_retop,
        pc:        decode_pc,
        dest:      decode_dest,
        result:    '0,
        target:    decode_target,
        bptag:     decode_bptag,
        bptaken:   decode_bptaken,
        forwarded: decode_forward
      };
    end
    if (wb_beat) begin
      mem[wb_robid].error  <= wb_error;
      mem[wb_robid].ecause <= wb_ecause;
      mem[wb_robid].result <= wb_result;
    end
  end

  // read stage
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= executed[rd_ptr[`ROB_IDX_W-1:0]] && !rd_empty;
    end
  end

  always_ff @(posedge clk) begin
    ret_entry <= mem[rd_ptr[`ROB_IDX_W-1:0]];
  end

  // an accepted entry always finds a free slot by pointer distance
  a_no_accept_full: assert property (@(posedge clk) disable iff (!rst_n)
    decode_beat |-> occupancy < DEPTH);

  a_wb_occupied: assert property (@(posedge clk) disable iff (!rst_n)
    wb_beat |-> wb_in_range);

endmodule

`default_nettype wire

/* design/rob_top.sv */
// ret_valid covers non-error retirements only; traps show up on csr_valid
`default_nettype none
`timescale 1ns/10ps

`include "rob_defs.svh"

module rob_top
  import op_pkg::*, ret_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  decode_valid,
  input  logic                  decode_error,
  input  logic [1:0]            decode_ecause,
  input  retop_t                decode_retop,
  input  logic [`PC_W-1:0]      decode_pc,
  input  dest_t                 decode_dest,
  input  logic [`BPTAG_W-1:0]   decode_bptag,
  input  logic                  decode_bptaken,
  input  logic                  decode_forward,
  input  logic [`PC_W-1:0]      decode_target,
  output logic                  full,
  output logic [`ROB_IDX_W-1:0] robid,
  input  logic                  wb_valid,
  input  logic                  wb_error,
  input  ecause_t               wb_ecause,
  input  logic [`ROB_IDX_W-1:0] wb_robid,
  input  logic [`XLEN-1:0]      wb_result,
  input  logic [`PC_W-1:0]      csr_tvec,
  output logic                  flush,
  output logic [`PC_W-1:0]      flush_pc,
  output logic                  ret_valid,
  output logic                  commit,
  output logic [`REG_IDX_W-1:0] commit_idx,
  output logic [`XLEN-1:0]      commit_data,
  output logic                  ret_store,
  output logic                  ret_branch,
  output logic [`BPTAG_W-1:0]   ret_bptag,
  output logic                  ret_bptaken,
  output logic                  ret_csr,
  output logic                  csr_valid,
  output logic [`PC_W-1:0]      csr_epc,
  output ecause_t               csr_ecause,
  input  logic [`REG_IDX_W-1:0] rd_idx,
  output logic [`XLEN-1:0]      rd_data
);

  // head entry out of the read stage
  logic       q_ret_valid;
  rob_entry_t q_ret_entry;

  rob_queue u_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .decode_valid   (decode_valid),
    .decode_error   (decode_error),
    .decode_ecause  (decode_ecause),
    .decode_retop   (decode_retop),
    .decode_pc      (decode_pc),
    .decode_dest    (decode_dest),
    .decode_bptag   (decode_bptag),
    .decode_bptaken (decode_bptaken),
    .decode_forward (decode_forward),
    .decode_target  (decode_target),
    .full           (full),
    .robid          (robid),
    .wb_valid       (wb_valid),
    .wb_error       (wb_error),
    .wb_ecause      (wb_ecause),
    .wb_robid       (wb_robid),
    .wb_result      (wb_result),
    .flush          (flush),
    .ret_valid      (q_ret_valid),
    .ret_entry      (q_ret_entry)
  );

  retire_unit u_retire (
    .ret_valid   (q_ret_valid),
    .ret_entry   (q_ret_entry),
    .csr_tvec    (csr_tvec),
    .flush       (flush),
    .flush_pc    (flush_pc),
    .ret_ok      (ret_valid),
    .commit      (commit),
    .commit_idx  (commit_idx),
    .commit_data (commit_data),
    .ret_store   (ret_store),
    .ret_branch  (ret_branch),
    .ret_bptag   (ret_bptag),
    .ret_bptaken (ret_bptaken),
    .ret_csr     (ret_csr),
    .csr_valid   (csr_valid),
    .csr_epc     (csr_epc),
    .csr_ecause  (csr_ecause)
  );

  arch_regfile u_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .commit      (commit),
    .commit_idx  (commit_idx),
    .commit_data (commit_data),
    .rd_idx      (rd_idx),
    .rd_data     (rd_data)
  );

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/op_pkg.sv
design/ret_pkg.sv
design/rob_queue.sv
design/retire_unit.sv
design/arch_regfile.sv
design/rob_top.sv
bench/rob_tb.sv
